// File: all.f
ptw_cfg_pkg.sv
ptw_types_pkg.sv
ptw_if.sv
walk_ctx.sv
pte_check.sv
ptw_walk_fsm.sv
iotlb_update_fmt.sv
ptw_top.sv
tb_ptw.sv

// File: Bender.yml
package:
  name: sv39_ptw

sources:
  - ptw_cfg_pkg.sv
  - ptw_types_pkg.sv
  - ptw_if.sv
  - walk_ctx.sv
  - pte_check.sv
  - ptw_walk_fsm.sv
  - iotlb_update_fmt.sv
  - ptw_top.sv
  - target: test
    files:
      - tb_ptw.sv

// File: tb_ptw.sv
// Testbench for the Sv39 walker: random page tables, reference walk and field checks
`timescale 1ns/1ns

module tb_ptw import ptw_cfg_pkg::*; import ptw_types_pkg::*; ();

    localparam int unsigned NUM_TESTS   = 40;
    localparam int unsigned RST_CYCLES  = 16;
    localparam int unsigned TIMEOUT_CYC = NUM_TESTS * 64 + RST_CYCLES;
    localparam logic [31:0] SEED        = 32'hb8d7;

    logic                      clk_i;
    logic                      rst_ni;
    logic                      iotlb_access_i;
    logic                      iotlb_hit_i;
    logic [VLEN-1:0]           req_iova_i;
    logic                      is_store_i;
    logic [PSCID_W-1:0]        pscid_i;
    logic [PPNW-1:0]           iosatp_ppn_i;
    logic                      mem_ar_ready_i;
    logic                      mem_r_valid_i;
    logic [DATA_W-1:0]         mem_r_data_i;
    logic                      mem_r_err_i;
    logic                      mem_ar_valid_o;
    logic [PLEN-1:0]           mem_ar_addr_o;
    logic                      mem_r_ready_o;
    logic                      ptw_active_o;
    logic                      ptw_error_o;
    logic [CAUSE_W-1:0]        cause_code_o;
    logic                      update_o;
    logic                      up_is_2m_o;
    logic                      up_is_1g_o;
    logic [VLEN-PAGE_OFFS-1:0] up_vpn_o;
    logic [PSCID_W-1:0]        up_pscid_o;
    pte_t                      up_content_o;

    // Page table memory and addresses that answer with a bus error
    logic [DATA_W-1:0] pt_mem [logic [PLEN-1:0]];
    bit                err_map [logic [PLEN-1:0]];

    logic [31:0]       stim_lfsr;
    logic [31:0]       mem_lfsr;

    // Current request and its expected result
    logic [VLEN-1:0]           cur_iova;
    logic                      cur_store;
    logic [PSCID_W-1:0]        cur_pscid;
    logic [PPNW-1:0]           cur_root;
    logic                      exp_pending;
    logic                      exp_err;
    int                        exp_lvl;
    logic [DATA_W-1:0]         exp_content;
    logic [CAUSE_W-1:0]        exp_cause;
    logic [VLEN-PAGE_OFFS-1:0] exp_vpn;
    string                     test_name;
    int                        results_seen;

    // Entry addresses of the walk, one per level, and the next one to be read
    logic [PLEN-1:0]           exp_addr [3];
    int                        rd_idx;

    ptw_top UUT (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(inout logic [31:0] st, input int n, output logic [63:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            st  = lfsr_next(st);
            val = {val[62:0], st[0]};
        end
    endtask

    // Flags are {d, a, g, u, x, w, r, v}
    function automatic logic [63:0] make_pte(input logic [PPNW-1:0] ppn, input logic [7:0] f);
        return {10'd0, ppn, 2'b00, f};
    endfunction

    function automatic logic [63:0] read_entry(input logic [PLEN-1:0] a);
        if (pt_mem.exists(a)) begin
            return pt_mem[a];
        end
        return 64'd0;
    endfunction

    function automatic string scen_name(input int s);
        case (s)
            0:       return "leaf_4k";
            1:       return "leaf_1g";
            2:       return "leaf_2m";
            3:       return "misaligned";
            4:       return "leaf_ad_fault";
            5:       return "reserved";
            6:       return "ptr_at_lvl3";
            default: return "mem_error";
        endcase
    endfunction

    // Sv39 walk over the model memory, following the privileged spec rules
    function automatic void ref_walk(input logic [VLEN-1:0] iova, input logic store,
                                     input logic [PPNW-1:0] root, output logic is_err,
                                     output int lvl, output logic [63:0] content,
                                     output logic [CAUSE_W-1:0] cause);
        logic [PLEN-1:0] a;
        pte_t            e;
        logic            g_acc;
        a       = {root, iova[38:30], 3'b000};
        g_acc   = 1'b0;
        is_err  = 1'b1;
        content = '0;
        cause   = store ? CAUSE_STORE_PF : CAUSE_LOAD_PF;
        lvl     = 0;
        for (int l = 0; l < 3; l++) begin
            lvl = l;
            e   = pte_t'(read_entry(a));
            if (err_map.exists(a)) begin
                cause = CAUSE_PT_CORRUPT;
                return;
            end
            if (!e.v || (e.w && !e.r) || (e.reserved != 0)) begin
                return;
            end
            if (e.r || e.x) begin
                if (!e.a || !e.r || (store && !e.d)) return;
                // Superpage alignment
                if (l == 0 && e.ppn[17:0] != 0) return;
                if (l == 1 && e.ppn[8:0] != 0) return;
                is_err  = 1'b0;
                e.g     = e.g | g_acc;
                content = e;
                return;
            end
            if (e.a || e.d || e.u || l == 2) return;
            g_acc = g_acc | e.g;
            a     = {e.ppn, (l == 0) ? iova[29:21] : iova[20:12], 3'b000};
        end
    endfunction

    // Random request and a three level table chain, then the scenario's twist
    task automatic build_walk(input int scen);
        logic [63:0]     r;
        logic [63:0]     m;
        logic [PPNW-1:0] p [3];
        logic [PLEN-1:0] a [3];
        logic [63:0]     e [3];
        logic [7:0]      leaf_f;
        int              el;
        pt_mem.delete();
        err_map.delete();
        draw_bits(stim_lfsr, 39, r);
        cur_iova = r[38:0];
        draw_bits(stim_lfsr, 1, r);
        cur_store = r[0];
        draw_bits(stim_lfsr, 20, r);
        cur_pscid = r[19:0];
        draw_bits(stim_lfsr, 44, r);
        cur_root = r[43:0];
        for (int l = 0; l < 3; l++) begin
            draw_bits(stim_lfsr, 44, r);
            p[l] = r[43:0];
        end
        a[0] = {cur_root, cur_iova[38:30], 3'b000};
        a[1] = {p[0], cur_iova[29:21], 3'b000};
        a[2] = {p[1], cur_iova[20:12], 3'b000};
        // Pointer global bits and leaf g, u, x, w
        draw_bits(stim_lfsr, 6, r);
        leaf_f = {2'b11, r[2], r[3], r[4], r[5], 2'b11};
        e[0]   = make_pte(p[0], {2'b00, r[0], 5'b00001});
        e[1]   = make_pte(p[1], {2'b00, r[1], 5'b00001});
        e[2]   = make_pte(p[2], leaf_f);
        draw_bits(stim_lfsr, 7, m);
        el = int'(m[2:1]) % 3;
        case (scen)
            1: e[0] = make_pte({p[2][43:18], 18'd0}, leaf_f);
            2: e[1] = make_pte({p[2][43:9], 9'd0}, leaf_f);
            3: begin
                if (m[0]) e[0] = make_pte(p[2] | 44'd1, leaf_f);
                else      e[1] = make_pte(p[2] | 44'd1, leaf_f);
            end
            // Store sees d clear, load sees a clear
            4: e[2][7:6] = cur_store ? 2'b01 : 2'b10;
            5: e[1][60]  = 1'b1;
            6: e[2]      = make_pte(p[2], 8'b00000001);
            7: err_map[a[el]] = 1'b1;
            default: ;
        endcase
        // Rare bus error in the other scenarios too
        if (scen != 7 && m[6:3] == 4'd0) begin
            err_map[a[el]] = 1'b1;
        end
        // Every level that the walk reaches is read at the chain address
        for (int l = 0; l < 3; l++) begin
            pt_mem[a[l]] = e[l];
            exp_addr[l]  = a[l];
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // Memory port with random address and response delays
    initial begin : mem_model
        logic [63:0]     d;
        logic [PLEN-1:0] addr;
        mem_lfsr       = SEED;
        mem_ar_ready_i = 1'b0;
        mem_r_valid_i  = 1'b0;
        mem_r_data_i   = '0;
        mem_r_err_i    = 1'b0;
        forever begin
            @(posedge clk_i);
            if (mem_ar_valid_o) begin
                addr = mem_ar_addr_o;
                check_val({test_name, " ar_addr"}, exp_addr[rd_idx], addr);
                rd_idx++;
                draw_bits(mem_lfsr, 6, d);
                // Request and address must hold while the port stalls
                repeat (d[2:0]) begin
                    @(posedge clk_i);
                    check_val({test_name, " ar_valid hold"}, 1, mem_ar_valid_o);
                    check_val({test_name, " ar_addr hold"}, addr, mem_ar_addr_o);
                end
                mem_ar_ready_i <= 1'b1;
                @(posedge clk_i);
                check_val({test_name, " ar_valid hold"}, 1, mem_ar_valid_o);
                check_val({test_name, " ar_addr hold"}, addr, mem_ar_addr_o);
                mem_ar_ready_i <= 1'b0;
                repeat (d[5:3]) @(posedge clk_i);
                mem_r_valid_i <= 1'b1;
                mem_r_data_i  <= read_entry(addr);
                mem_r_err_i   <= (err_map.exists(addr) != 0);
                @(posedge clk_i);
                // The walker must be ready on the edge that takes the response
                check_val({test_name, " r_ready"}, 1, mem_r_ready_o);
                mem_r_valid_i <= 1'b0;
                mem_r_err_i   <= 1'b0;
            end
        end
    end

    // Outputs sampled mid cycle where they are stable
    initial begin : compare_results
        results_seen = 0;
        forever begin
            @(negedge clk_i);
            if (rst_ni && (update_o || ptw_error_o)) begin
                if (!exp_pending) begin
                    $display("A walk result appeared with no request outstanding");
                    $display("*** TEST FAILED ***");
                    $fatal(1, "unexpected result");
                end else begin
                    check_val({test_name, " active"}, 1, ptw_active_o);
                    check_val({test_name, " error"}, exp_err, ptw_error_o);
                    check_val({test_name, " update"}, !exp_err, update_o);
                    if (exp_err) begin
                        check_val({test_name, " cause"}, exp_cause, cause_code_o);
                    end else begin
                        check_val({test_name, " is_1g"}, exp_lvl == 0, up_is_1g_o);
                        check_val({test_name, " is_2m"}, exp_lvl == 1, up_is_2m_o);
                        check_val({test_name, " vpn"}, exp_vpn, up_vpn_o);
                        check_val({test_name, " pscid"}, cur_pscid, up_pscid_o);
                        check_val({test_name, " content"}, exp_content, up_content_o);
                    end
                    exp_pending = 1'b0;
                    results_seen++;
                end
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYC) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout, the walks did not finish within %0d cycles", TIMEOUT_CYC);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    initial begin : stimulus
        int   scen;
        logic busy_miss;
        stim_lfsr      = SEED;
        exp_pending    = 1'b0;
        rd_idx         = 0;
        rst_ni         = 1'b0;
        iotlb_access_i = 1'b0;
        iotlb_hit_i    = 1'b0;
        req_iova_i     = '0;
        is_store_i     = 1'b0;
        pscid_i        = '0;
        iosatp_ppn_i   = '0;
        test_name      = "reset";
        repeat (RST_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_val("reset ar_valid", 0, mem_ar_valid_o);
        check_val("reset update", 0, update_o);
        check_val("reset error", 0, ptw_error_o);
        check_val("reset active", 0, ptw_active_o);

        for (int i = 0; i < NUM_TESTS; i++) begin
            scen = i % 8;
            build_walk(scen);
            ref_walk(cur_iova, cur_store, cur_root, exp_err, exp_lvl, exp_content, exp_cause);
            exp_vpn   = cur_iova[VLEN-1:PAGE_OFFS];
            test_name = $sformatf("test%0d_%s", i, scen_name(scen));
            rd_idx    = 0;
            // Every third walk sees a second miss while busy
            busy_miss = (i % 3 == 1);
            @(posedge clk_i);
            exp_pending = 1'b1;
            req_iova_i     <= cur_iova;
            is_store_i     <= cur_store;
            pscid_i        <= cur_pscid;
            iosatp_ppn_i   <= cur_root;
            iotlb_access_i <= 1'b1;
            iotlb_hit_i    <= 1'b0;
            @(posedge clk_i);
            if (busy_miss) @(posedge clk_i);
            iotlb_access_i <= 1'b0;
            while (results_seen <= i) @(posedge clk_i);
            while (ptw_active_o) @(posedge clk_i);
            // Idle gap so a stray result is still caught
            repeat (2) @(posedge clk_i);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: ptw_top.sv
// Sv39 IOMMU page table walker top level
`timescale 1ns/1ns

module ptw_top import ptw_cfg_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    // IOTLB lookup monitor
    input  logic                      iotlb_access_i,
    input  logic                      iotlb_hit_i,
    // Request context
    input  logic [VLEN-1:0]           req_iova_i,
    input  logic                      is_store_i,
    input  logic [PSCID_W-1:0]        pscid_i,
    input  logic [PPNW-1:0]           iosatp_ppn_i,
    // Memory read port
    input  logic                      mem_ar_ready_i,
    input  logic                      mem_r_valid_i,
    input  logic [DATA_W-1:0]         mem_r_data_i,
    input  logic                      mem_r_err_i,
    output logic                      mem_ar_valid_o,
    output logic [PLEN-1:0]           mem_ar_addr_o,
    output logic                      mem_r_ready_o,
    // Status and errors
    output logic                      ptw_active_o,
    output logic                      ptw_error_o,
    output logic [CAUSE_W-1:0]        cause_code_o,
    // IOTLB update
    output logic                      update_o,
    output logic                      up_is_2m_o,
    output logic                      up_is_1g_o,
    output logic [VLEN-PAGE_OFFS-1:0] up_vpn_o,
    output logic [PSCID_W-1:0]        up_pscid_o,
    output ptw_types_pkg::pte_t       up_content_o
);

    pte_chk_if   chk ();
    iotlb_upd_if upd ();

    logic miss;
    logic start;
    logic descend;

    // A lookup without a hit starts a walk
    assign miss = iotlb_access_i & ~iotlb_hit_i;

    // Read data is the entry under check and the candidate leaf
    assign chk.pte     = ptw_types_pkg::pte_t'(mem_r_data_i);
    assign upd.content = ptw_types_pkg::pte_t'(mem_r_data_i);

    ptw_walk_fsm u_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .miss_i         (miss),
        .mem_ar_ready_i (mem_ar_ready_i),
        .mem_r_valid_i  (mem_r_valid_i),
        .mem_r_err_i    (mem_r_err_i),
        .chk            (chk.fsm_mp),
        .start_o        (start),
        .descend_o      (descend),
        .mem_ar_valid_o (mem_ar_valid_o),
        .mem_r_ready_o  (mem_r_ready_o),
        .update_o       (update_o),
        .ptw_active_o   (ptw_active_o),
        .ptw_error_o    (ptw_error_o),
        .cause_code_o   (cause_code_o)
    );

    walk_ctx u_ctx (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (start),
        .descend_i    (descend),
        .req_iova_i   (req_iova_i),
        .is_store_i   (is_store_i),
        .pscid_i      (pscid_i),
        .iosatp_ppn_i (iosatp_ppn_i),
        .chk          (chk.ctx_mp),
        .upd          (upd.ctx_mp),
        .pte_i        (chk.pte),
        .pptr_o       (mem_ar_addr_o)
    );

    pte_check u_chk (
        .chk (chk.chk_mp)
    );

    iotlb_update_fmt u_fmt (
        .upd          (upd.fmt_mp),
        .up_is_2m_o   (up_is_2m_o),
        .up_is_1g_o   (up_is_1g_o),
        .up_vpn_o     (up_vpn_o),
        .up_pscid_o   (up_pscid_o),
        .up_content_o (up_content_o)
    );

    // Read request and its address hold until the memory port accepts it
    a_ar_addr_stable: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (mem_ar_valid_o && !mem_ar_ready_i) |=> (mem_ar_valid_o && $stable(mem_ar_addr_o))
    );

endmodule

// File: iotlb_update_fmt.sv
// IOTLB update formatter: page size flags, tags and leaf content with global bit
`timescale 1ns/1ns

module iotlb_update_fmt import ptw_cfg_pkg::*; import ptw_types_pkg::*; (
    iotlb_upd_if.fmt_mp                 upd,
    output logic                        up_is_2m_o,
    output logic                        up_is_1g_o,
    output logic [VLEN-PAGE_OFFS-1:0]   up_vpn_o,
    output logic [PSCID_W-1:0]          up_pscid_o,
    output pte_t                        up_content_o
);

    // Leaf found in the first table maps 1G, in the second 2M
    assign up_is_1g_o = (upd.level == LVL1);
    assign up_is_2m_o = (upd.level == LVL2);

    // Tags pass straight through
    assign up_vpn_o   = upd.vpn;
    assign up_pscid_o = upd.pscid;

    always_comb begin
        up_content_o   = upd.content;
        // Global pointer above the leaf makes the mapping global
        up_content_o.g = upd.content.g | upd.global_flag;
    end

endmodule

// File: ptw_walk_fsm.sv
// Walk controller: read handshake, level sequencing, update and error reporting
`timescale 1ns/1ns

module ptw_walk_fsm import ptw_cfg_pkg::*; import ptw_types_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               miss_i,
    input  logic               mem_ar_ready_i,
    input  logic               mem_r_valid_i,
    input  logic               mem_r_err_i,
    pte_chk_if.fsm_mp          chk,
    output logic               start_o,
    output logic               descend_o,
    output logic               mem_ar_valid_o,
    output logic               mem_r_ready_o,
    output logic               update_o,
    output logic               ptw_active_o,
    output logic               ptw_error_o,
    output logic [CAUSE_W-1:0] cause_code_o
);

    walk_state_e        state_q, state_n;
    logic [CAUSE_W-1:0] cause_q, cause_n;

    always_comb begin
        state_n   = state_q;
        cause_n   = cause_q;
        start_o   = 1'b0;
        descend_o = 1'b0;
        update_o  = 1'b0;

        case (state_q)
            IDLE: begin
                // Misses are only taken here, busy misses are dropped
                if (miss_i) begin
                    start_o = 1'b1;
                    state_n = WAIT_GRANT;
                end
            end
            WAIT_GRANT: begin
                if (mem_ar_ready_i) begin
                    state_n = PTE_LOOKUP;
                end
            end
            PTE_LOOKUP: begin
                if (mem_r_valid_i) begin
                    // Bus error wins over whatever the data says
                    if (mem_r_err_i) begin
                        cause_n = CAUSE_PT_CORRUPT;
                        state_n = PROPAGATE_ERROR;
                    end else begin
                        case (chk.kind)
                            PTE_LEAF: begin
                                update_o = 1'b1;
                                state_n  = IDLE;
                            end
                            PTE_POINTER: begin
                                descend_o = 1'b1;
                                state_n   = WAIT_GRANT;
                            end
                            default: begin
                                // Page fault matching the access type
                                cause_n = chk.is_store ? CAUSE_STORE_PF : CAUSE_LOAD_PF;
                                state_n = PROPAGATE_ERROR;
                            end
                        endcase
                    end
                end
            end
            default: begin
                state_n = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            cause_q <= '0;
        end else begin
            state_q <= state_n;
            cause_q <= cause_n;
        end
    end

    assign mem_ar_valid_o = (state_q == WAIT_GRANT);
    assign mem_r_ready_o  = (state_q == PTE_LOOKUP);
    assign ptw_active_o   = (state_q != IDLE);
    assign ptw_error_o    = (state_q == PROPAGATE_ERROR);
    // Cause only shown while the error is reported
    assign cause_code_o   = ptw_error_o ? cause_q : '0;

    // An accepted entry must decode to a known kind
    a_kind_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (mem_r_ready_o && mem_r_valid_i && !mem_r_err_i) |-> !$isunknown(chk.kind)
    );

endmodule

// File: pte_check.sv
// Entry checker: classifies one Sv39 entry as leaf, pointer or fault
`timescale 1ns/1ns

module pte_check import ptw_cfg_pkg::*; import ptw_types_pkg::*; (
    pte_chk_if.chk_mp chk
);

    logic is_leaf;
    logic invalid;
    logic misaligned;
    logic leaf_fault;
    logic ptr_fault;

    always_comb begin
        // R or X marks a leaf, otherwise a pointer
        is_leaf = chk.pte.r | chk.pte.x;

        // Not valid, write without read, or reserved bits in use
        invalid = !chk.pte.v
                || (chk.pte.w && !chk.pte.r)
                || (|chk.pte.reserved);

        // Superpage must have its low PPN bits clear
        misaligned = ((chk.level == LVL1) && (|chk.pte.ppn[2*VPNW-1:0]))
                   || ((chk.level == LVL2) && (|chk.pte.ppn[VPNW-1:0]));

        // A clear, no read permission, or a store to a clean page
        leaf_fault = !chk.pte.a
                   || !chk.pte.r
                   || (chk.is_store && !chk.pte.d)
                   || misaligned;

        // D, A and U are reserved in pointers
        // No table exists below the last level
        ptr_fault = chk.pte.a
                  || chk.pte.d
                  || chk.pte.u
                  || (chk.level == LVL3);

        if (invalid) begin
            chk.kind = PTE_FAULT;
        end else if (is_leaf) begin
            chk.kind = leaf_fault ? PTE_FAULT : PTE_LEAF;
        end else begin
            chk.kind = ptr_fault ? PTE_FAULT : PTE_POINTER;
        end
    end

endmodule

// File: walk_ctx.sv
// Walk context: captured request, current level, global flag and table pointer
`timescale 1ns/1ns

module walk_ctx import ptw_cfg_pkg::*; import ptw_types_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               start_i,
    input  logic               descend_i,
    input  logic [VLEN-1:0]    req_iova_i,
    input  logic               is_store_i,
    input  logic [PSCID_W-1:0] pscid_i,
    input  logic [PPNW-1:0]    iosatp_ppn_i,
    pte_chk_if.ctx_mp          chk,
    iotlb_upd_if.ctx_mp        upd,
    input  pte_t               pte_i,
    output logic [PLEN-1:0]    pptr_o
);

    pt_level_e          level_q;
    logic               global_q;
    logic [VLEN-1:0]    iova_q;
    logic               store_q;
    logic [PSCID_W-1:0] pscid_q;
    logic [PLEN-1:0]    pptr_q;

    // Pointer and level for the next table
    logic [VPNW-1:0]    next_vpn;
    pt_level_e          next_level;
    logic [PLEN-1:0]    next_pptr;

    always_comb begin
        // VPN slice indexes the table one level down
        case (level_q)
            LVL1: begin
                next_vpn   = iova_q[PAGE_OFFS+2*VPNW-1:PAGE_OFFS+VPNW];
                next_level = LVL2;
            end
            default: begin
                next_vpn   = iova_q[PAGE_OFFS+VPNW-1:PAGE_OFFS];
                next_level = LVL3;
            end
        endcase
        next_pptr = {pte_i.ppn, next_vpn, {PTE_BYTES_LOG2{1'b0}}};
    end

    // Level and global flag are control state
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            level_q  <= LVL1;
            global_q <= 1'b0;
        end else if (start_i) begin
            level_q  <= LVL1;
            global_q <= 1'b0;
        end else if (descend_i) begin
            level_q  <= next_level;
            // A global pointer makes the whole subtree global
            global_q <= global_q | pte_i.g;
        end
    end

    // Request payload and table pointer
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            iova_q  <= req_iova_i;
            store_q <= is_store_i;
            pscid_q <= pscid_i;
            // Root table from iosatp, indexed by VPN[2]
            pptr_q  <= {iosatp_ppn_i, req_iova_i[VLEN-1:PAGE_OFFS+2*VPNW],
                        {PTE_BYTES_LOG2{1'b0}}};
        end else if (descend_i) begin
            pptr_q  <= next_pptr;
        end
    end

    assign pptr_o          = pptr_q;
    assign chk.level       = level_q;
    assign chk.is_store    = store_q;
    assign upd.vpn         = iova_q[VLEN-1:PAGE_OFFS];
    assign upd.pscid       = pscid_q;
    assign upd.level       = level_q;
    assign upd.global_flag = global_q;

    // The controller must fault a pointer found in the last table
    a_no_descend_at_lvl3: assert property (
        @(posedge clk_i) disable iff (!rst_ni) descend_i |-> level_q != LVL3
    );

endmodule

// File: ptw_if.sv
// Walker interfaces: entry checker bundle and IOTLB update bundle
`timescale 1ns/1ns

// Entry under check, its context and the check result
interface pte_chk_if import ptw_types_pkg::*; ();

    pte_t      pte;
    pt_level_e level;
    logic      is_store;
    pte_kind_e kind;

    // Context side provides level and access type
    modport ctx_mp (
        output level,
        output is_store
    );

    // Checker sees the whole entry and returns its kind
    modport chk_mp (
        input  pte,
        input  level,
        input  is_store,
        output kind
    );

    // Controller needs the result and the access type for the cause
    modport fsm_mp (
        input  kind,
        input  is_store
    );

endinterface

// Fields that form one IOTLB update
interface iotlb_upd_if import ptw_types_pkg::*; ();

    logic [ptw_cfg_pkg::VLEN-ptw_cfg_pkg::PAGE_OFFS-1:0] vpn;
    logic [ptw_cfg_pkg::PSCID_W-1:0]                     pscid;
    pt_level_e                                            level;
    logic                                                 global_flag;
    pte_t                                                 content;

    modport ctx_mp (
        output vpn,
        output pscid,
        output level,
        output global_flag
    );

    // Formatter reads everything, content comes straight from read data
    modport fmt_mp (
        input  vpn,
        input  pscid,
        input  level,
        input  global_flag,
        input  content
    );

endinterface

// File: ptw_types_pkg.sv
// Sv39 walker types: page table entry layout and the walk enums
package ptw_types_pkg;

    import ptw_cfg_pkg::*;

    // Sv39 page table entry, most significant field first
    typedef struct packed {
        // Bits 63:54, must be zero without Svnapot or Svpbmt
        logic [9:0]      reserved;
        // Physical page number of the next table or the leaf page
        logic [PPNW-1:0] ppn;
        // Free for software use
        logic [1:0]      rsw;
        logic            d;
        logic            a;
        logic            g;
        logic            u;
        logic            x;
        logic            w;
        logic            r;
        logic            v;
    } pte_t;

    // Walk controller states
    typedef enum logic [1:0] {
        IDLE,
        // Read address offered, waiting for the memory port
        WAIT_GRANT,
        // Waiting for the read response
        PTE_LOOKUP,
        // One cycle error report
        PROPAGATE_ERROR
    } walk_state_e;

    // Table levels, LVL1 maps 1G pages
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } pt_level_e;

    // Result of checking one entry
    typedef enum logic [1:0] {
        PTE_LEAF,
        PTE_POINTER,
        PTE_FAULT
    } pte_kind_e;

endpackage

// File: ptw_cfg_pkg.sv
// Sv39 walker configuration: address geometry, memory port widths and cause codes
package ptw_cfg_pkg;

    // Sv39 virtual and physical address geometry
    localparam int unsigned VLEN           = 39;
    localparam int unsigned PLEN           = 56;
    localparam int unsigned PPNW           = 44;
    localparam int unsigned VPNW           = 9;
    localparam int unsigned PAGE_OFFS      = 12;

    // Each entry is 8 bytes wide
    localparam int unsigned PTE_BYTES_LOG2 = 3;

    // Address space tag width
    localparam int unsigned PSCID_W        = 20;

    // Memory read data width
    localparam int unsigned DATA_W         = 64;

    // Fault reporting
    localparam int unsigned CAUSE_W        = 11;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_PF    = 11'd13;
    localparam logic [CAUSE_W-1:0] CAUSE_STORE_PF   = 11'd15;
    // Failed read of a table entry
    localparam logic [CAUSE_W-1:0] CAUSE_PT_CORRUPT = 11'd274;

endpackage
